// File: filelist.f
src/cpu_pkg.sv
src/ifetch.sv
src/mem_stage.sv
src/bus_arbiter.sv
src/scratch_ram.sv
src/mem_subsys_top.sv
test/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_mem_subsys \
  -f filelist.f -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: FAIL" sim.log 2>/dev/null && exit 1
grep -q "RESULT: PASS" sim.log 2>/dev/null || exit 1
exit 0

// File: src/bus_arbiter.sv
module bus_arbiter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::bus_req_t req0_i,
  input  cpu_pkg::bus_req_t req1_i,
  output cpu_pkg::bus_rsp_t rsp0_o,
  output cpu_pkg::bus_rsp_t rsp1_o,
  output cpu_pkg::bus_req_t mem_req_o,
  input  cpu_pkg::bus_rsp_t mem_rsp_i
);
  import cpu_pkg::*;

  logic busy_q;
  logic owner_q;   // 0 = memory stage, 1 = fetch
  logic owner;

  // master 0 wins whenever the bus is free
  assign owner = busy_q ? owner_q : !req0_i.cyc;

  assign mem_req_o = owner ? req1_i : req0_i;

  assign rsp0_o.ack = mem_rsp_i.ack && !owner;
  assign rsp1_o.ack = mem_rsp_i.ack && owner;
  assign rsp0_o.dat = mem_rsp_i.dat;
  assign rsp1_o.dat = mem_rsp_i.dat;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
    end
    else if (busy_q)
    begin
      if (mem_rsp_i.ack)
        busy_q <= 1'b0;
    end
    else if (mem_req_o.cyc)
    begin
      busy_q  <= 1'b1;   // ram takes it this cycle
      owner_q <= owner;
    end
  end

  one_ack_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rsp0_o.ack && rsp1_o.ack));

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

  localparam int          RAM_WORDS = 1024;
  localparam int          RAM_AW    = $clog2(RAM_WORDS);  // word index bits
  localparam logic [31:0] RESET_PC  = 32'h0000_0000;

  // major instruction class, bits 31:28
  typedef enum logic [3:0] {
    T_INH    = 4'h0,
    T_ALU    = 4'h9,
    T_LOAD   = 4'hc,
    T_STORE  = 4'hd,
    T_BRANCH = 4'he
  } ir_type_e;

  // access size from op bits 1:0
  typedef enum logic [1:0] {
    SZ_WORD  = 2'h0,
    SZ_HALF  = 2'h1,
    SZ_BYTE  = 2'h2,
    SZ_WORD2 = 2'h3   // same as word
  } mem_size_e;

  typedef struct packed {
    logic        cyc;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;   // bit 3 is the msb lane
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } bus_rsp_t;

  typedef struct packed {
    logic [63:0] ir;
    logic [31:0] pc;
    logic [31:0] result;
    logic [1:0]  reg_write;
    logic        halt;
  } stage_t;

endpackage

// File: src/ifetch.sv
module ifetch (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              redirect_i,
  input  logic [31:0]       target_i,
  input  logic              hold_i,
  output cpu_pkg::bus_req_t bus_req_o,
  input  cpu_pkg::bus_rsp_t bus_rsp_i,
  output logic [63:0]       ir_o,
  output logic [31:0]       pc_o,
  output logic              valid_o
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    F_IDLE,
    F_WORD0,
    F_WORD1,
    F_VALID,
    F_FLUSH
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic [31:0]  pc_q;
  logic [31:0]  pc_d;
  logic [31:0]  adr_q;
  logic [63:0]  ir_q;
  logic [63:0]  ir_d;
  logic         is_long;

  assign is_long = ir_q[32];   // size bit of first word
  assign valid_o = (state_q == F_VALID);
  assign ir_o    = ir_q;
  assign pc_o    = pc_q;

  always_comb
  begin
    bus_req_o.cyc = (state_q == F_WORD0) || (state_q == F_WORD1) || (state_q == F_FLUSH);
    bus_req_o.we  = 1'b0;
    bus_req_o.dat = 32'h0;
    bus_req_o.sel = 4'hf;
    case (state_q)
      F_WORD1: bus_req_o.adr = pc_q + 32'd4;
      F_FLUSH: bus_req_o.adr = adr_q;   // finish the abandoned read
      default: bus_req_o.adr = pc_q;
    endcase
  end

  always_comb
  begin
    state_d = state_q;
    pc_d    = pc_q;
    ir_d    = ir_q;
    case (state_q)
      F_IDLE:  state_d = F_WORD0;
      F_WORD0:
        if (bus_rsp_i.ack)
        begin
          ir_d    = {bus_rsp_i.dat, 32'h0};
          state_d = bus_rsp_i.dat[0] ? F_WORD1 : F_VALID;
        end
      F_WORD1:
        if (bus_rsp_i.ack)
        begin
          ir_d[31:0] = bus_rsp_i.dat;
          state_d    = F_VALID;
        end
      F_VALID:
        if (!hold_i)
        begin
          pc_d    = pc_q + (is_long ? 32'd8 : 32'd4);
          state_d = F_WORD0;
        end
      F_FLUSH: if (bus_rsp_i.ack) state_d = F_WORD0;
      default: state_d = F_IDLE;
    endcase
    if (redirect_i)
    begin
      pc_d    = target_i;
      state_d = (bus_req_o.cyc && !bus_rsp_i.ack) ? F_FLUSH : F_WORD0;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= F_IDLE;
      pc_q    <= RESET_PC;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ir_q <= ir_d;
    if (state_q != F_FLUSH)
      adr_q <= bus_req_o.adr;
  end

  // an instruction only completes on the cycle after a read is acknowledged
  valid_rise_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(valid_o) |-> !bus_req_o.cyc && $past(bus_rsp_i.ack));

endmodule

// File: src/mem_stage.sv
module mem_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::stage_t   stage_i,
  input  logic [31:0]       reg_data1_i,
  input  logic              pc_set_i,
  input  logic              exc_i,
  input  logic              stall_i,
  output cpu_pkg::stage_t   stage_o,
  output logic              pc_set_o,
  output logic              stall_o,
  output cpu_pkg::bus_req_t bus_req_o,
  input  cpu_pkg::bus_rsp_t bus_rsp_i
);
  import cpu_pkg::*;

  ir_type_e   ir_type;
  logic [3:0] ir_op;
  logic       ir_size;
  mem_size_e  mem_size;
  logic       is_load;
  logic       is_store;
  logic       jump_reg;
  logic       advance;
  stage_t     stage_next;
  logic       pc_set_next;

  assign ir_type  = ir_type_e'(stage_i.ir[31:28]);
  assign ir_op    = stage_i.ir[27:24];
  assign ir_size  = stage_i.ir[0];
  assign mem_size = mem_size_e'(ir_op[1:0]);
  assign is_load  = (ir_type == T_LOAD);
  assign is_store = (ir_type == T_STORE);

  // jump through register forms
  assign jump_reg = (ir_type == T_INH) &&
                    ((ir_op == 4'h1 && !ir_size) || ir_op == 4'h5);

  assign stall_o = bus_req_o.cyc && !bus_rsp_i.ack;
  assign advance = !(stall_i || stall_o);

  always_comb
  begin
    bus_req_o.cyc = is_load || is_store || exc_i;   // exc reads the vector
    bus_req_o.we  = is_store;
    bus_req_o.adr = stage_i.result;
    bus_req_o.dat = reg_data1_i;
    case (mem_size)
      SZ_HALF: bus_req_o.sel = stage_i.result[1] ? 4'b0011 : 4'b1100;
      SZ_BYTE:
        case (stage_i.result[1:0])
          2'b00:   bus_req_o.sel = 4'b1000;
          2'b01:   bus_req_o.sel = 4'b0100;
          2'b10:   bus_req_o.sel = 4'b0010;
          default: bus_req_o.sel = 4'b0001;
        endcase
      default: bus_req_o.sel = 4'b1111;
    endcase
  end

  always_comb
  begin
    stage_next  = stage_i;
    pc_set_next = pc_set_i;
    if (is_load)
      stage_next.result = bus_rsp_i.dat;   // raw word, no extraction
    if (jump_reg)
    begin
      stage_next.pc = stage_i.result;
      pc_set_next   = 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      stage_o  <= '0;
      pc_set_o <= 1'b0;
    end
    else if (advance)
    begin
      stage_o  <= stage_next;
      pc_set_o <= pc_set_next;
    end
  end

  store_sel_a: assert property (@(posedge clk_i) disable iff (rst_i)
    bus_req_o.cyc && bus_req_o.we |-> bus_req_o.sel != 4'h0);

endmodule

// File: src/mem_subsys_top.sv
module mem_subsys_top (
  input  logic            clk_i,
  input  logic            rst_i,
  input  cpu_pkg::stage_t stage_i,
  input  logic [31:0]     reg_data1_i,
  input  logic            pc_set_i,
  input  logic            exc_i,
  input  logic            stall_i,
  output cpu_pkg::stage_t stage_o,
  output logic            pc_set_o,
  output logic            stall_o,
  input  logic            fetch_redirect_i,
  input  logic [31:0]     fetch_target_i,
  input  logic            fetch_hold_i,
  output logic [63:0]     fetch_ir_o,
  output logic [31:0]     fetch_pc_o,
  output logic            fetch_valid_o
);
  import cpu_pkg::*;

  bus_req_t stage_req;
  bus_rsp_t stage_rsp;
  bus_req_t fetch_req;
  bus_rsp_t fetch_rsp;
  bus_req_t ram_req;
  bus_rsp_t ram_rsp;

  mem_stage u_mem_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stage_i     (stage_i),
    .reg_data1_i (reg_data1_i),
    .pc_set_i    (pc_set_i),
    .exc_i       (exc_i),
    .stall_i     (stall_i),
    .stage_o     (stage_o),
    .pc_set_o    (pc_set_o),
    .stall_o     (stall_o),
    .bus_req_o   (stage_req),
    .bus_rsp_i   (stage_rsp)
  );

  ifetch u_ifetch (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .redirect_i (fetch_redirect_i),
    .target_i   (fetch_target_i),
    .hold_i     (fetch_hold_i),
    .bus_req_o  (fetch_req),
    .bus_rsp_i  (fetch_rsp),
    .ir_o       (fetch_ir_o),
    .pc_o       (fetch_pc_o),
    .valid_o    (fetch_valid_o)
  );

  // memory stage takes priority
  bus_arbiter u_arbiter (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req0_i    (stage_req),
    .req1_i    (fetch_req),
    .rsp0_o    (stage_rsp),
    .rsp1_o    (fetch_rsp),
    .mem_req_o (ram_req),
    .mem_rsp_i (ram_rsp)
  );

  scratch_ram u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

endmodule

// File: src/scratch_ram.sv
module scratch_ram (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cpu_pkg::bus_req_t req_i,
  output cpu_pkg::bus_rsp_t rsp_o
);
  import cpu_pkg::*;

  logic [31:0]       mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;
  logic              ack_q;
  logic [31:0]       dat_q;
  logic              accept;

  assign word_idx = req_i.adr[RAM_AW+1:2];
  assign accept   = req_i.cyc && !ack_q;   // no new access in the ack cycle

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      dat_q <= mem[word_idx];
      if (req_i.we)
      begin
        for (int i = 0; i < 4; i++)
          if (req_i.sel[i])
            mem[word_idx][8*i +: 8] <= req_i.dat[8*i +: 8];   // sel[3] is byte 0
      end
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;

endmodule

// File: test/tb_mem_subsys.sv
module tb_mem_subsys;
  timeunit 1ns;
  timeprecision 1ps;
  import cpu_pkg::*;

  localparam int          NUM_TESTS  = 6;
  localparam int          TIMEOUT_NS = NUM_TESTS * 200 * 10;
  localparam int          PROG_LEN   = 8;
  localparam logic [31:0] PROG_BASE  = 32'h0000_0200;
  localparam logic [7:0]  LONG_MASK  = 8'b1011_0010;   // long program slots

  logic        clk_i;
  logic        rst_i;
  stage_t      stage_i;
  logic [31:0] reg_data1_i;
  logic        pc_set_i;
  logic        exc_i;
  logic        stall_i;
  stage_t      stage_o;
  logic        pc_set_o;
  logic        stall_o;
  logic        fetch_redirect_i;
  logic [31:0] fetch_target_i;
  logic        fetch_hold_i;
  logic [63:0] fetch_ir_o;
  logic [31:0] fetch_pc_o;
  logic        fetch_valid_o;

  int          errors;
  logic [31:0] lfsr_q;
  logic [31:0] model [RAM_WORDS];   // expected ram words
  logic [31:0] prog_pc [PROG_LEN];
  logic [63:0] prog_ir [PROG_LEN];

  mem_subsys_top UUT (.*);

  always #5 clk_i = ~clk_i;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  // big-endian lanes, offset 0 is bits 31:24
  function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] dat,
                                              input logic [1:0] size, input logic [1:0] offs);
    logic [31:0] mask;
    case (size)
      2'd1:    mask = offs[1] ? 32'h0000_ffff : 32'hffff_0000;
      2'd2:    mask = 32'hff00_0000 >> {offs, 3'b000};
      default: mask = 32'hffff_ffff;
    endcase
    return (old & ~mask) | (dat & mask);
  endfunction

  function automatic logic [63:0] make_ir(input logic [3:0] cls, input logic [3:0] op,
                                          input logic sz);
    return {32'h0, cls, op, 23'h0, sz};
  endfunction

  function automatic stage_t make_stage(input logic [63:0] ir, input logic [31:0] pc,
                                        input logic [31:0] result);
    stage_t s;
    s           = '0;
    s.ir        = ir;
    s.pc        = pc;
    s.result    = result;
    s.reg_write = 2'b01;
    return s;
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_stage(output logic stalled);
    stalled = 1'b0;
    @(negedge clk_i);
    while (stall_o)
    begin
      stalled = 1'b1;
      @(negedge clk_i);
    end
  endtask

  task automatic run_stage(input stage_t s, input logic [31:0] data, input logic pc_set,
                           output stage_t got, output logic got_pc_set, output logic stalled);
    @(posedge clk_i);
    stage_i     <= s;
    reg_data1_i <= data;
    pc_set_i    <= pc_set;
    wait_stage(stalled);
    @(posedge clk_i);   // stage_o loads here
    stage_i     <= '0;
    reg_data1_i <= '0;
    pc_set_i    <= 1'b0;
    @(negedge clk_i);
    got        = stage_o;
    got_pc_set = pc_set_o;
  endtask

  task automatic store_mem(input logic [31:0] addr, input logic [31:0] data,
                           input logic [1:0] size);
    stage_t            got;
    logic              got_pc_set;
    logic              stalled;
    logic [RAM_AW-1:0] idx;
    idx = addr[RAM_AW+1:2];
    run_stage(make_stage(make_ir(T_STORE, {2'b00, size}, 1'b0), addr, addr), data, 1'b0,
              got, got_pc_set, stalled);
    check_equal("stall_o during store", 64'(stalled), 64'h1);
    check_equal("stage_o.result after store", 64'(got.result), 64'(addr));
    model[idx] = merge_lanes(model[idx], data, size, addr[1:0]);
  endtask

  task automatic load_expect(input logic [31:0] addr);
    stage_t got;
    logic   got_pc_set;
    logic   stalled;
    run_stage(make_stage(make_ir(T_LOAD, 4'h0, 1'b0), addr, addr), 32'h0, 1'b0,
              got, got_pc_set, stalled);
    check_equal("stall_o during load", 64'(stalled), 64'h1);
    check_equal("stage_o.result after load", 64'(got.result), 64'(model[addr[RAM_AW+1:2]]));
  endtask

  task automatic inh_case(input logic [3:0] op, input logic sz, input logic pset);
    stage_t s;
    stage_t got;
    logic   got_pc_set;
    logic   stalled;
    logic   jump;
    s    = make_stage(make_ir(T_INH, op, sz), 32'h0000_0300 + {28'h0, op}, rand_word());
    jump = (op == 4'h5) || (op == 4'h1 && !sz);
    run_stage(s, 32'h0, pset, got, got_pc_set, stalled);
    check_equal("stage_o.pc", 64'(got.pc), 64'(jump ? s.result : s.pc));
    check_equal("pc_set_o", 64'(got_pc_set), 64'(jump | pset));
    check_equal("stage_o.result", 64'(got.result), 64'(s.result));
  endtask

  task automatic start_fetch(input logic [31:0] target);
    @(posedge clk_i);
    fetch_redirect_i <= 1'b1;
    fetch_target_i   <= target;
    fetch_hold_i     <= 1'b0;
    @(posedge clk_i);
    fetch_redirect_i <= 1'b0;
  endtask

  task automatic collect_fetch();
    for (int i = 0; i < PROG_LEN; i++)
    begin
      @(negedge clk_i);
      while (!fetch_valid_o)
        @(negedge clk_i);
      check_equal("fetch_pc_o", 64'(fetch_pc_o), 64'(prog_pc[i]));
      check_equal("fetch_ir_o", fetch_ir_o, prog_ir[i]);
    end
  endtask

  task automatic reset_values();
    @(negedge clk_i);
    check_equal("stall_o", 64'(stall_o), 64'h0);
    check_equal("pc_set_o", 64'(pc_set_o), 64'h0);
    check_equal("stage_o.ir", stage_o.ir, 64'h0);
    check_equal("stage_o.pc", 64'(stage_o.pc), 64'h0);
    check_equal("stage_o.result", 64'(stage_o.result), 64'h0);
    check_equal("stage_o.reg_write", 64'(stage_o.reg_write), 64'h0);
    check_equal("stage_o.halt", 64'(stage_o.halt), 64'h0);
    check_equal("fetch_valid_o", 64'(fetch_valid_o), 64'h0);
  endtask

  task automatic word_access();
    for (int i = 0; i < 6; i++)
      store_mem(32'h0000_0080 + 32'(8 * i), rand_word(), (i % 2 == 1) ? SZ_WORD2 : SZ_WORD);
    for (int i = 5; i >= 0; i--)
      load_expect(32'h0000_0080 + 32'(8 * i));
  endtask

  task automatic byte_lanes();
    logic [31:0] base;
    base = 32'h0000_00c0;
    store_mem(base, rand_word(), SZ_WORD);
    store_mem(base + 32'd1, rand_word(), SZ_BYTE);
    store_mem(base + 32'd2, rand_word(), SZ_HALF);
    load_expect(base);
    store_mem(base + 32'd4, rand_word(), SZ_WORD);
    store_mem(base + 32'd7, rand_word(), SZ_BYTE);
    store_mem(base + 32'd4, rand_word(), SZ_HALF);
    load_expect(base + 32'd4);
  endtask

  task automatic stall_and_redirect();
    stage_t held;
    stage_t pending;
    held    = make_stage(make_ir(T_INH, 4'h5, 1'b0), 32'h0000_0400, rand_word());
    pending = make_stage(make_ir(T_INH, 4'h3, 1'b0), 32'h0000_0500, rand_word());
    @(posedge clk_i);
    stage_i <= held;
    @(posedge clk_i);
    stage_i <= pending;
    stall_i <= 1'b1;
    repeat (4)
    begin
      @(negedge clk_i);
      check_equal("stage_o.pc under stall", 64'(stage_o.pc), 64'(held.result));
      check_equal("pc_set_o under stall", 64'(pc_set_o), 64'h1);
    end
    @(posedge clk_i);
    stall_i <= 1'b0;
    @(posedge clk_i);
    stage_i <= '0;
    @(negedge clk_i);
    check_equal("stage_o.pc after stall", 64'(stage_o.pc), 64'(pending.pc));
    check_equal("pc_set_o after stall", 64'(pc_set_o), 64'h0);
    inh_case(4'h1, 1'b0, 1'b0);
    inh_case(4'h1, 1'b1, 1'b0);
    inh_case(4'h5, 1'b1, 1'b0);
    inh_case(4'h2, 1'b0, 1'b1);
  endtask

  task automatic fetch_program();
    logic [31:0] pc;
    logic [31:0] w0;
    logic [31:0] w1;
    pc = PROG_BASE;
    for (int i = 0; i < PROG_LEN; i++)
    begin
      w0         = rand_word();
      w0[0]      = LONG_MASK[i];   // size bit
      prog_pc[i] = pc;
      store_mem(pc, w0, SZ_WORD);
      if (LONG_MASK[i])
      begin
        w1 = rand_word();
        store_mem(pc + 32'd4, w1, SZ_WORD);
        prog_ir[i] = {w0, w1};
        pc         = pc + 32'd8;
      end
      else
      begin
        prog_ir[i] = {w0, 32'h0};
        pc         = pc + 32'd4;
      end
    end
    start_fetch(PROG_BASE);
    collect_fetch();
    @(posedge clk_i);
    fetch_hold_i <= 1'b1;
  endtask

  task automatic bus_sharing();
    start_fetch(PROG_BASE);
    fork
      collect_fetch();
      begin
        for (int i = 0; i < 6; i++)
          store_mem(32'h0000_0100 + 32'(4 * i), rand_word(), SZ_WORD);
        for (int i = 0; i < 6; i++)
          load_expect(32'h0000_0100 + 32'(4 * i));
        load_expect(32'h0000_0080);   // older data intact
      end
    join
    @(posedge clk_i);
    fetch_hold_i <= 1'b1;
  endtask

  initial
  begin
    clk_i            = 1'b0;
    errors           = 0;
    lfsr_q           = 32'hec7d_d92d;
    rst_i            <= 1'b1;
    stage_i          <= '0;
    reg_data1_i      <= '0;
    pc_set_i         <= 1'b0;
    exc_i            <= 1'b0;
    stall_i          <= 1'b0;
    fetch_redirect_i <= 1'b0;
    fetch_target_i   <= '0;
    fetch_hold_i     <= 1'b1;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
    reset_values();
    word_access();
    byte_lanes();
    stall_and_redirect();
    fetch_program();
    bus_sharing();
    $display("checks done with %0d errors", errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
